/* sources.f */
vdp_pkg.sv
vdp_port_ctrl.sv
vdp_ctrl_regs.sv
vdp_status_read.sv
vdp_palette.sv
vdp_register.sv
vdp_register_asserts.sv
tb_vdp_register.sv

/* tb_vdp_register.sv */
// Testbench for the VDP CPU-side register block
// reset is the clock (20 ns period), clk21m the active-high reset
// CPU inputs change on the falling clock edge, outputs are sampled there too
// VRAM acknowledges follow their requests two cycles later
// Summary also includes failures of the bound concurrent assertions
`timescale 1ns/1ns

module tb_vdp_register
  import vdp_pkg::*;
();

  localparam int TIMEOUT = 32;

  logic       reset;
  logic       clk21m;
  logic       req;
  logic       wrt;
  port_t      port;
  byte_t      dbo;
  logic       ack;
  byte_t      dbi;
  logic       hsync;
  logic       field;
  logic       vd;
  logic       hd;
  logic [1:0] dot_state;
  logic       vsync_int_n;
  logic       hsync_int_n;
  byte_t      vram_rd_data;
  logic       vram_wr_ack;
  logic       vram_addr_set_ack;
  byte_t      vram_wr_data;
  vram_addr_t vram_addr;
  logic       vram_wr_req;
  logic       vram_addr_set_req;
  logic       clr_vsync_int;
  logic       clr_hsync_int;
  pal_idx_t   pal_addr;
  byte_t      pal_rb;
  byte_t      pal_g;
  logic       disp_on;
  logic       hsync_int_en;
  logic       vsync_int_en;
  logic [6:0] name_addr;
  byte_t      frame_col;
  logic       interlace;
  logic       pal_mode;
  byte_t      hint_line;
  byte_t      vstart_line;
  disp_mode_t disp_mode;
  logic       high_res;
  logic       sprite_mode2;

  int     errors;
  bit     timed_out;
  integer seed;
  int     vclr_cnt;
  int     hclr_cnt;
  logic   wr_ack_q;
  logic   addr_ack_q;

  vdp_register DUT (.*);

  always #10 reset = ~reset;

  // VRAM side model, two-stage echo of each request toggle
  always @(negedge reset) begin
    wr_ack_q          <= vram_wr_req;
    vram_wr_ack       <= wr_ack_q;
    addr_ack_q        <= vram_addr_set_req;
    vram_addr_set_ack <= addr_ack_q;
  end

  // Free-running dot phase
  always @(negedge reset) begin
    dot_state <= dot_state + 2'd1;
  end

  // Count clear pulses, one per high cycle
  always @(negedge reset) begin
    if (clr_vsync_int) vclr_cnt++;
    if (clr_hsync_int) hclr_cnt++;
  end

  // ---------------------------------------------------------------------
  // Reporting
  // ---------------------------------------------------------------------
  task automatic finish_run();
    int assert_fails;
    assert_fails = DUT.u_asserts.fails;
    $display("Value errors: %0d, assertion failures: %0d, timeout: %0d",
             errors, assert_fails, timed_out);
    if (timed_out || errors != 0 || assert_fails != 0) begin
      $display("Simulation finished: FAIL");
    end else begin
      $display("Simulation finished: PASS");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    timed_out = 1'b1;
    finish_run();
  endtask

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("error %s: expected %0h, actual %0h", test, expected, actual);
    end
  endtask

  // ---------------------------------------------------------------------
  // Bus tasks
  // ---------------------------------------------------------------------
  task automatic bus_cycle(input logic write, input port_t p, input byte_t data,
                           output byte_t rdata);
    int n;
    @(negedge reset);
    req  = 1'b1;
    wrt  = write;
    port = p;
    dbo  = data;
    @(negedge reset);
    req = 1'b0;
    n   = 0;
    while (!ack) begin
      if (n == TIMEOUT) report_timeout("ack on the CPU bus");
      @(negedge reset);
      n++;
    end
    rdata = dbi;
    // Idle cycle so ack is gone before the next req
    @(negedge reset);
  endtask

  task automatic write_port(input port_t p, input byte_t data);
    byte_t unused;
    bus_cycle(1'b1, p, data, unused);
  endtask

  task automatic read_port(input port_t p, output byte_t data);
    bus_cycle(1'b0, p, 8'h00, data);
  endtask

  // Data byte then 10 and register number, output settles two edges later
  task automatic write_reg(input reg_num_t num, input byte_t data);
    write_port(PORT_CTRL, data);
    write_port(PORT_CTRL, {2'b10, num});
    repeat (2) @(negedge reset);
  endtask

  task automatic wait_vram_ack(input bit addr_side);
    int n;
    n = 0;
    while (addr_side ? (vram_addr_set_req != vram_addr_set_ack)
                     : (vram_wr_req != vram_wr_ack)) begin
      if (n == TIMEOUT) report_timeout("VRAM acknowledge");
      @(negedge reset);
      n++;
    end
  endtask

  task automatic wait_palette_idle();
    int n;
    n = 0;
    while (DUT.u_palette.wr_pending) begin
      if (n == TIMEOUT) report_timeout("palette write slot");
      @(negedge reset);
      n++;
    end
  endtask

  // ---------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------
  initial begin
    byte_t val;
    byte_t rd;
    byte_t b0;
    byte_t b1;
    logic  old_req;
    int    cnt0;
    byte_t rb [2];
    byte_t g  [2];
    reset = 1'b0;
    clk21m = 1'b1;
    req = 1'b0;
    wrt = 1'b0;
    port = PORT_VRAM;
    dbo = 8'h00;
    hsync = 1'b0;
    field = 1'b0;
    vd = 1'b0;
    hd = 1'b0;
    dot_state = 2'd0;
    vsync_int_n = 1'b1;
    hsync_int_n = 1'b1;
    vram_rd_data = 8'h00;
    vram_wr_ack = 1'b0;
    vram_addr_set_ack = 1'b0;
    wr_ack_q = 1'b0;
    addr_ack_q = 1'b0;
    pal_addr = 4'd0;
    errors = 0;
    timed_out = 1'b0;
    vclr_cnt = 0;
    hclr_cnt = 0;
    seed = 57;

    repeat (8) @(negedge reset);
    clk21m = 1'b0;
    @(negedge reset);
    check_value("reset ack", 0, ack);
    check_value("reset clr_vsync_int", 0, clr_vsync_int);
    check_value("reset clr_hsync_int", 0, clr_hsync_int);

    // Direct write and mode latch on hsync
    val = $random(seed);
    write_reg(REG_FRAME_COL, val);
    check_value("R7 frame_col", val, frame_col);
    // M5..M3 = 011 with IE1, M2 M1 = 00, display on with IE0
    write_reg(REG_MODE0, 8'h16);
    write_reg(REG_MODE1, 8'h60);
    check_value("mode before hsync", GRAPHIC1, disp_mode);
    check_value("sprite_mode2 in G1", 0, sprite_mode2);
    check_value("hsync_int_en", 1, hsync_int_en);
    check_value("vsync_int_en", 1, vsync_int_en);
    hsync = 1'b1;
    @(negedge reset);
    hsync = 1'b0;
    check_value("mode after hsync", GRAPHIC4, disp_mode);
    check_value("disp_on after hsync", 1, disp_on);
    check_value("high_res in G4", 0, high_res);
    check_value("sprite_mode2 in G4", 1, sprite_mode2);
    // M5 alone selects the 512-dot G5
    write_reg(REG_MODE0, 8'h18);
    hsync = 1'b1;
    @(negedge reset);
    hsync = 1'b0;
    check_value("mode G5", GRAPHIC5, disp_mode);
    check_value("high_res in G5", 1, high_res);
    // Interlace, two-page and PAL, two-page swaps name bit 5 with field
    write_reg(REG_OPTIONS, 8'h0E);
    check_value("R9 interlace", 1, interlace);
    check_value("R9 pal_mode", 1, pal_mode);
    write_reg(REG_NAME, 8'h1F);
    field = 1'b1;
    @(negedge reset);
    check_value("name_addr field 1", 7'h3F, name_addr);
    field = 1'b0;
    @(negedge reset);
    check_value("name_addr field 0", 7'h1F, name_addr);

    // R19 write also drops a pending line interrupt
    val = $random(seed);
    cnt0 = hclr_cnt;
    write_reg(REG_HINT_LINE, val);
    check_value("R19 hint_line", val, hint_line);
    check_value("R19 clr_hsync_int pulses", cnt0 + 1, hclr_cnt);

    // Indirect writes from R22 upward
    write_reg(REG_INDIRECT, 8'd22);
    b0 = $random(seed);
    b1 = b0 ^ 8'hA5;
    write_port(PORT_INDIRECT, b0);
    write_port(PORT_INDIRECT, b1);
    repeat (2) @(negedge reset);
    check_value("R23 via port 3", b1, vstart_line);
    // Pointer at R17 without increment, the write must not move it
    write_reg(REG_INDIRECT, 8'h91);
    write_port(PORT_INDIRECT, 8'd23);
    write_port(PORT_INDIRECT, ~b1);
    repeat (2) @(negedge reset);
    check_value("R17 protected", b1, vstart_line);

    // VRAM address set and data write
    write_reg(REG_VRAM_HI, 8'd5);
    b0 = $random(seed);
    b1 = $random(seed);
    old_req = vram_addr_set_req;
    write_port(PORT_CTRL, b0);
    write_port(PORT_CTRL, {2'b01, b1[5:0]});
    check_value("vram_addr", {3'd5, b1[5:0], b0}, vram_addr);
    check_value("vram_addr_set_req toggle", !old_req, vram_addr_set_req);
    wait_vram_ack(1'b1);
    val = $random(seed);
    old_req = vram_wr_req;
    write_port(PORT_VRAM, val);
    check_value("vram_wr_req toggle", !old_req, vram_wr_req);
    check_value("vram_wr_data", val, vram_wr_data);
    wait_vram_ack(1'b0);

    // Status reads
    write_reg(REG_STATUS_SEL, 8'd0);
    vsync_int_n = 1'b0;
    cnt0 = vclr_cnt;
    read_port(PORT_CTRL, rd);
    vsync_int_n = 1'b1;
    check_value("S#0 read", 8'h80, rd);
    check_value("clr_vsync_int pulses", cnt0 + 1, vclr_cnt);
    write_reg(REG_STATUS_SEL, 8'd1);
    hsync_int_n = 1'b0;
    cnt0 = hclr_cnt;
    read_port(PORT_CTRL, rd);
    hsync_int_n = 1'b1;
    check_value("S#1 read", (8'(VDP_ID) << 1) | 8'h01, rd);
    check_value("clr_hsync_int pulses", cnt0 + 1, hclr_cnt);
    write_reg(REG_STATUS_SEL, 8'd9);
    read_port(PORT_CTRL, rd);
    check_value("S#9 read", 8'hFF, rd);

    // Palette entries 3 and 4 through auto-increment
    write_reg(REG_PAL_IDX, 8'd3);
    for (int i = 0; i < 2; i++) begin
      rb[i] = $random(seed);
      g[i]  = $random(seed);
      write_port(PORT_PALETTE, rb[i]);
      write_port(PORT_PALETTE, g[i]);
    end
    wait_palette_idle();
    for (int i = 0; i < 2; i++) begin
      pal_addr = 4'd3 + 4'(i);
      @(negedge reset);
      check_value("palette red/blue", rb[i], pal_rb);
      check_value("palette green", g[i], pal_g);
    end

    finish_run();
  end

endmodule

/* vdp_register_asserts.sv */
// Concurrent checks bound into the VDP register block top level
// Clock is reset, asynchronous active-high reset is clk21m
// Assumes req never comes while ack is still high
// Palette check assumes an odd dot state at least every third cycle
`timescale 1ns/1ns

module vdp_register_asserts (
  input logic       reset,
  input logic       clk21m,
  input logic       req,
  input logic       ack,
  input logic       clr_vsync_int,
  input logic       clr_hsync_int,
  input logic       pal_wr_toggle,
  input logic       pal_wr_en,
  input logic [1:0] dot_state
);

  int fails = 0;

  // ---------------------------------------------------------------------
  // CPU handshake
  // ---------------------------------------------------------------------
  ack_follows_req: assert property (@(posedge reset) disable iff (clk21m)
    req |=> ack)
    else begin
      fails++;
      $error("ack missing in the cycle after req");
    end

  ack_only_after_req: assert property (@(posedge reset) disable iff (clk21m)
    ack |-> $past(req))
    else begin
      fails++;
      $error("ack without a req in the cycle before");
    end

  // First cycle out of reset
  ack_low_after_reset: assert property (@(posedge reset) $fell(clk21m) |-> !ack)
    else begin
      fails++;
      $error("ack high in the first cycle after reset");
    end

  // ---------------------------------------------------------------------
  // Pulses and palette slots
  // ---------------------------------------------------------------------
  vclr_one_cycle: assert property (@(posedge reset) disable iff (clk21m)
    clr_vsync_int |=> !clr_vsync_int)
    else begin
      fails++;
      $error("clr_vsync_int longer than one cycle");
    end

  hclr_one_cycle: assert property (@(posedge reset) disable iff (clk21m)
    clr_hsync_int |=> !clr_hsync_int)
    else begin
      fails++;
      $error("clr_hsync_int longer than one cycle");
    end

  // Posted entry goes to memory in one of the next odd dot states
  pal_odd_dot: assert property (@(posedge reset) disable iff (clk21m)
    $changed(pal_wr_toggle) |->
      ##[0:2] (pal_wr_en && (dot_state == 2'b01 || dot_state == 2'b10)))
    else begin
      fails++;
      $error("palette entry not written in the next odd dot state");
    end

endmodule

bind vdp_register vdp_register_asserts u_asserts (
  .reset         (reset),
  .clk21m        (clk21m),
  .req           (req),
  .ack           (ack),
  .clr_vsync_int (clr_vsync_int),
  .clr_hsync_int (clr_hsync_int),
  .pal_wr_toggle (pal_wr_toggle),
  .pal_wr_en     (u_palette.wr_en),
  .dot_state     (dot_state)
);

/* vdp_register.sv */
// Top of the VDP CPU-side register block
// reset is the clock, clk21m the asynchronous active-high reset
// Port sequencing feeds the register bank, status read and palette
`timescale 1ns/1ns

module vdp_register
  import vdp_pkg::*;
(
  input  logic       reset,
  input  logic       clk21m,
  // CPU bus
  input  logic       req,
  input  logic       wrt,
  input  port_t      port,
  input  byte_t      dbo,
  output logic       ack,
  output byte_t      dbi,
  // Video timing
  input  logic       hsync,
  input  logic       field,
  input  logic       vd,
  input  logic       hd,
  input  logic [1:0] dot_state,
  input  logic       vsync_int_n,
  input  logic       hsync_int_n,
  // VRAM side
  input  byte_t      vram_rd_data,
  input  logic       vram_wr_ack,
  input  logic       vram_addr_set_ack,
  output byte_t      vram_wr_data,
  output vram_addr_t vram_addr,
  output logic       vram_wr_req,
  output logic       vram_addr_set_req,
  // Interrupt clears
  output logic       clr_vsync_int,
  output logic       clr_hsync_int,
  // Palette readout
  input  pal_idx_t   pal_addr,
  output byte_t      pal_rb,
  output byte_t      pal_g,
  // Register values
  output logic       disp_on,
  output logic       hsync_int_en,
  output logic       vsync_int_en,
  output logic [6:0] name_addr,
  output byte_t      frame_col,
  output logic       interlace,
  output logic       pal_mode,
  output byte_t      hint_line,
  output byte_t      vstart_line,
  output disp_mode_t disp_mode,
  output logic       high_res,
  output logic       sprite_mode2
);

  // Links between the blocks
  reg_wr_t     reg_wr;
  logic        reg_wr_pulse;
  status_num_t status_num;
  pal_wr_t     pal_wr;
  logic        pal_wr_toggle;

  vdp_port_ctrl u_port_ctrl (.*);

  vdp_ctrl_regs u_ctrl_regs (.*);

  vdp_status_read u_status_read (.*);

  vdp_palette u_palette (.*);

endmodule

/* vdp_palette.sv */
// Palette write scheduling and 16-entry palette memory
// Writes go only in dot states 01 and 10, display reads get the rest
// Read data appears one cycle after the address
// Entry on pal_wr must stay stable until the write is taken
`timescale 1ns/1ns

module vdp_palette
  import vdp_pkg::*;
(
  input  logic       reset,
  input  logic       clk21m,
  input  pal_wr_t    pal_wr,
  input  logic       pal_wr_toggle,
  input  logic [1:0] dot_state,
  input  pal_idx_t   pal_addr,
  output byte_t      pal_rb,
  output byte_t      pal_g
);

  logic     wr_ack;
  logic     odd_dot;
  logic     wr_pending;
  logic     wr_en;
  pal_idx_t mem_addr;
  byte_t    mem_rb [16];
  byte_t    mem_g  [16];

  // ---------------------------------------------------------------------
  // Write scheduling
  // ---------------------------------------------------------------------
  assign odd_dot    = (dot_state == 2'b01) || (dot_state == 2'b10);
  assign wr_pending = pal_wr_toggle != wr_ack;
  assign wr_en      = odd_dot & wr_pending;
  // Write index steals the port for that cycle
  assign mem_addr   = wr_en ? pal_wr.idx : pal_addr;

  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      wr_ack <= 1'b0;
    end else if (wr_en) begin
      wr_ack <= ~wr_ack;
    end
  end

  // ---------------------------------------------------------------------
  // Memory
  // ---------------------------------------------------------------------
  // Both colour bytes written together
  always_ff @(posedge reset) begin
    if (wr_en) begin
      mem_rb[mem_addr] <= pal_wr.rb;
      mem_g[mem_addr]  <= pal_wr.g;
    end
    pal_rb <= mem_rb[mem_addr];
    pal_g  <= mem_g[mem_addr];
  end

endmodule

/* vdp_status_read.sv */
// CPU read data and interrupt clear pulses
// Only S#0 to S#2 exist, other status numbers read 0xFF
// Clear pulses last one cycle since req lasts one cycle
`timescale 1ns/1ns

module vdp_status_read
  import vdp_pkg::*;
(
  input  logic        reset,
  input  logic        clk21m,
  input  logic        req,
  input  logic        wrt,
  input  port_t       port,
  input  status_num_t status_num,
  input  reg_wr_t     reg_wr,
  input  logic        reg_wr_pulse,
  input  byte_t       vram_rd_data,
  input  logic        vsync_int_n,
  input  logic        hsync_int_n,
  input  logic        field,
  input  logic        vd,
  input  logic        hd,
  output byte_t       dbi,
  output logic        clr_vsync_int,
  output logic        clr_hsync_int
);

  logic  rd_any;
  logic  rd_status;
  logic  hint_wr;
  byte_t status_byte;

  assign rd_any    = req & ~wrt;
  assign rd_status = rd_any & (port == PORT_CTRL);
  // R19 write or R0 with IE1 set drops a pending line interrupt
  assign hint_wr   = reg_wr_pulse & ((reg_wr.num == REG_HINT_LINE) |
                                     ((reg_wr.num == REG_MODE0) & reg_wr.data[4]));

  // Status mux, command engine bits read as 0
  always_comb begin
    case (status_num)
      4'd0:    status_byte = {~vsync_int_n, 7'b0000000};
      4'd1:    status_byte = {2'b00, VDP_ID, ~hsync_int_n};
      4'd2:    status_byte = {1'b0, vd, hd, 1'b0, 2'b11, field, 1'b0};
      default: status_byte = READ_UNUSED;
    endcase
  end

  // Read data holds until the next read
  always_ff @(posedge reset) begin
    if (rd_any) begin
      case (port)
        PORT_VRAM: dbi <= vram_rd_data;
        PORT_CTRL: dbi <= status_byte;
        default:   dbi <= READ_UNUSED;
      endcase
    end
  end

  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      clr_vsync_int <= 1'b0;
      clr_hsync_int <= 1'b0;
    end else begin
      clr_vsync_int <= rd_status & (status_num == 4'd0);
      clr_hsync_int <= (rd_status & (status_num == 4'd1)) | hint_wr;
    end
  end

endmodule

/* vdp_ctrl_regs.sv */
// VDP control register bank and display mode decode
// Writes land two cycles after the pulse source samples the byte
// Mode bits and display-on take effect on the next hsync high edge
// Two-page bitmap mode swaps name table bit 5 with field
`timescale 1ns/1ns

module vdp_ctrl_regs
  import vdp_pkg::*;
(
  input  logic       reset,
  input  logic       clk21m,
  input  reg_wr_t    reg_wr,
  input  logic       reg_wr_pulse,
  input  logic       hsync,
  input  logic       field,
  output logic       disp_on,
  output logic       hsync_int_en,
  output logic       vsync_int_en,
  output logic [6:0] name_addr,
  output byte_t      frame_col,
  output logic       interlace,
  output logic       pal_mode,
  output byte_t      hint_line,
  output byte_t      vstart_line,
  output disp_mode_t disp_mode,
  output logic       high_res,
  output logic       sprite_mode2
);

  reg_wr_t    wr_q;
  logic       wr_v;
  logic [2:0] m543_stg;
  logic [1:0] m21_stg;
  logic       disp_on_stg;
  logic [2:0] m543;
  logic [1:0] m21;
  logic [6:0] r2_name;
  logic       two_page;
  logic       bitmap;
  logic [4:0] mode_code;

  // Input stage for the write bus
  always_ff @(posedge reset) begin
    if (reg_wr_pulse) begin
      wr_q <= reg_wr;
    end
  end

  // ---------------------------------------------------------------------
  // Register bank
  // ---------------------------------------------------------------------
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      wr_v         <= 1'b0;
      m543_stg     <= 3'd0;
      m21_stg      <= 2'd0;
      disp_on_stg  <= 1'b0;
      hsync_int_en <= 1'b0;
      vsync_int_en <= 1'b0;
      r2_name      <= 7'd0;
      frame_col    <= 8'd0;
      pal_mode     <= 1'b0;
      two_page     <= 1'b0;
      interlace    <= 1'b0;
      hint_line    <= 8'd0;
      vstart_line  <= 8'd0;
    end else begin
      wr_v <= reg_wr_pulse;
      if (wr_v) begin
        case (wr_q.num)
          REG_MODE0: begin
            m543_stg     <= wr_q.data[3:1];
            hsync_int_en <= wr_q.data[4];
          end
          REG_MODE1: begin
            // Bit 3 is M2, bit 4 is M1
            m21_stg      <= {wr_q.data[3], wr_q.data[4]};
            vsync_int_en <= wr_q.data[5];
            disp_on_stg  <= wr_q.data[6];
          end
          REG_NAME:      r2_name <= wr_q.data[6:0];
          REG_FRAME_COL: frame_col <= wr_q.data;
          REG_OPTIONS: begin
            pal_mode  <= wr_q.data[1];
            two_page  <= wr_q.data[2];
            interlace <= wr_q.data[3];
          end
          REG_HINT_LINE: hint_line <= wr_q.data;
          REG_VSTART:    vstart_line <= wr_q.data;
          default: ;
        endcase
      end
    end
  end

  // Mode change only between lines
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      m543    <= 3'd0;
      m21     <= 2'd0;
      disp_on <= 1'b0;
    end else if (hsync) begin
      m543    <= m543_stg;
      m21     <= m21_stg;
      disp_on <= disp_on_stg;
    end
  end

  // ---------------------------------------------------------------------
  // Mode decode
  // ---------------------------------------------------------------------
  assign mode_code    = {m543, m21};
  // G4 and above are bitmap modes
  assign bitmap       = m543[2] | (m543 == 3'b011);
  assign name_addr    = (bitmap && two_page) ? {r2_name[6], field, r2_name[4:0]} : r2_name;
  // G5 and G6 use 512-dot lines
  assign high_res     = (m543[2:1] == 2'b10) && (m21 == 2'b00);
  assign sprite_mode2 = (m21 == 2'b00) && (m543[2] | m543[1]);

  always_comb begin
    case (mode_code)
      GRAPHIC1, TEXT1, MULTI, GRAPHIC2, TEXT1Q, MULTIQ,
      GRAPHIC3, TEXT2, GRAPHIC4, GRAPHIC5, GRAPHIC6, GRAPHIC7:
        disp_mode = disp_mode_t'(mode_code);
      default:
        disp_mode = UNDEFINED;
    endcase
  end

endmodule

/* vdp_port_ctrl.sv */
// CPU port sequencer for the VDP register block
// One-cycle req, ack one cycle later, no back-pressure
// Port 1 read form of the address sets the address only
// VRAM side uses toggle handshakes, pending while req differs from ack
`timescale 1ns/1ns

module vdp_port_ctrl
  import vdp_pkg::*;
(
  input  logic        reset,
  input  logic        clk21m,
  input  logic        req,
  input  logic        wrt,
  input  port_t       port,
  input  byte_t       dbo,
  input  logic        vram_wr_ack,
  input  logic        vram_addr_set_ack,
  output logic        ack,
  output reg_wr_t     reg_wr,
  output logic        reg_wr_pulse,
  output status_num_t status_num,
  output byte_t       vram_wr_data,
  output vram_addr_t  vram_addr,
  output logic        vram_wr_req,
  output logic        vram_addr_set_req,
  output pal_wr_t     pal_wr,
  output logic        pal_wr_toggle
);

  logic       p1_first;
  logic       p2_first;
  byte_t      p1_data;
  byte_t      pal_rb_buf;
  logic [2:0] r14_hi;
  pal_idx_t   r16_idx;
  reg_num_t   r17_ptr;
  logic       r17_inc;

  logic wr_vram;
  logic p1_first_wr;
  logic p1_second;
  logic p2_first_wr;
  logic p2_second;
  logic ind_wr;
  logic rd_ctrl;

  // ---------------------------------------------------------------------
  // Request decode
  // ---------------------------------------------------------------------
  assign wr_vram     = req & wrt & (port == PORT_VRAM);
  assign p1_first_wr = req & wrt & (port == PORT_CTRL) & p1_first;
  assign p1_second   = req & wrt & (port == PORT_CTRL) & ~p1_first;
  assign p2_first_wr = req & wrt & (port == PORT_PALETTE) & p2_first;
  assign p2_second   = req & wrt & (port == PORT_PALETTE) & ~p2_first;
  assign ind_wr      = req & wrt & (port == PORT_INDIRECT);
  assign rd_ctrl     = req & ~wrt & (port == PORT_CTRL);

  // ---------------------------------------------------------------------
  // Control state
  // ---------------------------------------------------------------------
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      ack               <= 1'b0;
      reg_wr_pulse      <= 1'b0;
      p1_first          <= 1'b1;
      p2_first          <= 1'b1;
      vram_wr_req       <= 1'b0;
      vram_addr_set_req <= 1'b0;
      pal_wr_toggle     <= 1'b0;
      r14_hi            <= 3'd0;
      status_num        <= 4'd0;
      r16_idx           <= 4'd0;
      r17_ptr           <= 6'd0;
      r17_inc           <= 1'b0;
    end else begin
      ack <= req;
      // Bit 7 of the second byte selects a register write
      // Indirect writes never reach R17 itself
      reg_wr_pulse <= (p1_second & dbo[7]) | (ind_wr & (r17_ptr != REG_INDIRECT));

      // Status read restarts the two-byte sequence
      if (rd_ctrl || p1_second) begin
        p1_first <= 1'b1;
      end else if (p1_first_wr) begin
        p1_first <= 1'b0;
      end

      if (wr_vram) begin
        vram_wr_req <= ~vram_wr_ack;
      end
      // Write and read forms both just load the address
      if (p1_second && !dbo[7]) begin
        vram_addr_set_req <= ~vram_addr_set_ack;
      end

      // Palette pair, index steps after each entry
      if (p2_first_wr) begin
        p2_first <= 1'b0;
      end else if (p2_second) begin
        p2_first      <= 1'b1;
        pal_wr_toggle <= ~pal_wr_toggle;
        r16_idx       <= r16_idx + 4'd1;
      end

      if (ind_wr && r17_inc) begin
        r17_ptr <= r17_ptr + 6'd1;
      end

      // Registers kept here, applied one cycle after the pulse rises
      if (reg_wr_pulse) begin
        case (reg_wr.num)
          REG_VRAM_HI:    r14_hi <= reg_wr.data[2:0];
          REG_STATUS_SEL: status_num <= reg_wr.data[3:0];
          REG_PAL_IDX: begin
            r16_idx  <= reg_wr.data[3:0];
            p2_first <= 1'b1;
          end
          REG_INDIRECT: begin
            r17_ptr <= reg_wr.data[5:0];
            // Bit 7 set means no auto-increment
            r17_inc <= ~reg_wr.data[7];
          end
          default: ;
        endcase
      end
    end
  end

  // Data path registers
  always_ff @(posedge reset) begin
    if (wr_vram) begin
      vram_wr_data <= dbo;
    end
    if (p1_first_wr) begin
      p1_data <= dbo;
    end
    if (p1_second && !dbo[7]) begin
      vram_addr <= {r14_hi, dbo[5:0], p1_data};
    end
    if (p1_second && dbo[7]) begin
      reg_wr <= '{num: dbo[5:0], data: p1_data};
    end else if (ind_wr) begin
      reg_wr <= '{num: r17_ptr, data: dbo};
    end
    if (p2_first_wr) begin
      pal_rb_buf <= dbo;
    end
    // Whole entry released at once on the green byte
    if (p2_second) begin
      pal_wr <= '{idx: r16_idx, rb: pal_rb_buf, g: dbo};
    end
  end

endmodule

/* vdp_pkg.sv */
// Shared types and constants for the VDP CPU-side register block
// Register and status numbers follow the MSX2 VDP numbering
// Only the registers handled by this block are listed
package vdp_pkg;

  // Meaningful widths
  typedef logic [7:0]  byte_t;
  typedef logic [5:0]  reg_num_t;
  typedef logic [3:0]  pal_idx_t;
  typedef logic [3:0]  status_num_t;
  typedef logic [16:0] vram_addr_t;
  typedef logic [1:0]  port_t;

  // CPU ports, 0x98 to 0x9B on the real machine
  localparam port_t PORT_VRAM     = 2'd0;
  localparam port_t PORT_CTRL     = 2'd1;
  localparam port_t PORT_PALETTE  = 2'd2;
  localparam port_t PORT_INDIRECT = 2'd3;

  // Control register numbers
  localparam reg_num_t REG_MODE0      = 6'd0;
  localparam reg_num_t REG_MODE1      = 6'd1;
  localparam reg_num_t REG_NAME       = 6'd2;
  localparam reg_num_t REG_FRAME_COL  = 6'd7;
  localparam reg_num_t REG_OPTIONS    = 6'd9;
  localparam reg_num_t REG_VRAM_HI    = 6'd14;
  localparam reg_num_t REG_STATUS_SEL = 6'd15;
  localparam reg_num_t REG_PAL_IDX    = 6'd16;
  localparam reg_num_t REG_INDIRECT   = 6'd17;
  localparam reg_num_t REG_HINT_LINE  = 6'd19;
  localparam reg_num_t REG_VSTART     = 6'd23;

  // Chip identity in S#1, V9938 class
  localparam logic [4:0] VDP_ID = 5'd2;
  localparam byte_t READ_UNUSED = 8'hFF;

  // One register write
  typedef struct packed {
    reg_num_t num;
    byte_t    data;
  } reg_wr_t;

  // One palette entry
  typedef struct packed {
    pal_idx_t idx;
    byte_t    rb;
    byte_t    g;
  } pal_wr_t;

  // Mode code is {M5, M4, M3, M2, M1}
  typedef enum logic [4:0] {
    GRAPHIC1  = 5'b00000,
    TEXT1     = 5'b00001,
    MULTI     = 5'b00010,
    GRAPHIC2  = 5'b00100,
    TEXT1Q    = 5'b00101,
    MULTIQ    = 5'b00110,
    GRAPHIC3  = 5'b01000,
    TEXT2     = 5'b01001,
    GRAPHIC4  = 5'b01100,
    GRAPHIC5  = 5'b10000,
    GRAPHIC6  = 5'b10100,
    GRAPHIC7  = 5'b11100,
    UNDEFINED = 5'b11111
  } disp_mode_t;

endpackage
